// ==== flist.f ====
+incdir+include
rtl/datapathPkg.sv
rtl/registerFile.sv
rtl/selectEncode.sv
rtl/alu.sv
rtl/memory.sv
rtl/dataPath.sv
testbench/dataPathTb.sv

// ==== include/datapath_config.svh ====
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// word and storage sizes
`define DP_WIDTH      32
`define DP_REGS       16
`define DP_MEM_DEPTH  512

// instruction field layout
// opcode 31..27, ra 26..23, rb 22..19, rc 18..15, C 18..0
`define DP_RA_LSB     23
`define DP_RB_LSB     19
`define DP_RC_LSB     15
`define DP_C_BITS     19

`endif

// ==== rtl/alu.sv ====
`include "datapath_config.svh"

module alu (
    input  datapathPkg::aluOpT      op,
    input  datapathPkg::wordT       a,         // from Y
    input  datapathPkg::wordT       b,         // from the bus
    output logic [2*`DP_WIDTH-1:0]  result
);

    localparam int ShiftBits = $clog2(`DP_WIDTH);

    datapathPkg::wordT              narrow;    // 32-bit result of the simple ops
    logic signed [2*`DP_WIDTH-1:0]  product;
    logic [ShiftBits-1:0]           shiftCount;

    assign shiftCount = b[ShiftBits-1:0];

    // both operands are signed, so they extend to 64 bits before the multiply
    assign product = $signed(a) * $signed(b);

    always_comb begin
        case (op)
            datapathPkg::aluAdd: begin
                narrow = a + b;
            end
            datapathPkg::aluSub: begin
                narrow = a - b;
            end
            datapathPkg::aluAnd: begin
                narrow = a & b;
            end
            datapathPkg::aluOr: begin
                narrow = a | b;
            end
            datapathPkg::aluShl: begin
                narrow = a << shiftCount;
            end
            datapathPkg::aluShr: begin
                narrow = a >> shiftCount;    // logical, zero fill
            end
            datapathPkg::aluNeg: begin
                narrow = -b;
            end
            datapathPkg::aluNot: begin
                narrow = ~b;
            end
            datapathPkg::aluInc: begin
                narrow = b + 1'b1;           // PC + 1 during fetch
            end
            default: begin
                narrow = b;                  // pass, also covers mul's low half unused
            end
        endcase
    end

    // multiply keeps all 64 bits, everything else lands in Z low
    always_comb begin
        if (op == datapathPkg::aluMul) begin
            result = product;
        end else begin
            result = {{`DP_WIDTH{1'b0}}, narrow};
        end
    end

endmodule

// ==== rtl/dataPath.sv ====
`include "datapath_config.svh"

module dataPath (
    input  logic               clock,
    input  logic               reset,
    // register load strobes
    input  logic               pcIn,
    input  logic               irIn,
    input  logic               yIn,
    input  logic               zHighIn,
    input  logic               zLowIn,
    input  logic               marIn,
    input  logic               mdrIn,
    input  logic               outPortIn,
    input  logic               rIn,
    // bus drive strobes
    input  logic               pcOut,
    input  logic               zHighOut,
    input  logic               zLowOut,
    input  logic               mdrOut,
    input  logic               inPortOut,
    input  logic               cSignOut,
    input  logic               rOut,
    // register select
    input  logic               gra,
    input  logic               grb,
    input  logic               grc,
    input  logic               baOut,
    // memory
    input  logic               mdRead,
    input  logic               read,
    input  logic               write,
    // ALU
    input  logic               add,
    input  logic               sub,
    input  logic               andOp,
    input  logic               orOp,
    input  logic               shl,
    input  logic               shr,
    input  logic               neg,
    input  logic               notOp,
    input  logic               mul,
    input  logic               incPc,
    // I/O ports
    input  datapathPkg::wordT  inPort,
    output datapathPkg::wordT  outPort
);

    localparam int AddrBits = $clog2(`DP_MEM_DEPTH);

    datapathPkg::wordT     bus;
    datapathPkg::wordT     pc;
    datapathPkg::wordT     ir;
    datapathPkg::wordT     y;
    logic [2*`DP_WIDTH-1:0] z;            // high half 63..32, low half 31..0
    datapathPkg::wordT     mar;
    datapathPkg::wordT     mdr;
    datapathPkg::wordT     mdrNext;
    datapathPkg::wordT     memData;
    datapathPkg::wordT     regData;
    datapathPkg::wordT     cSign;
    datapathPkg::regIndexT regIndex;
    logic                  regWrite;
    logic                  regRead;
    datapathPkg::aluOpT    aluOp;
    logic [2*`DP_WIDTH-1:0] aluResult;

    // single bus source, fixed priority among the out strobes
    always_comb begin
        if (regRead) begin
            bus = regData;
        end else if (pcOut) begin
            bus = pc;
        end else if (zHighOut) begin
            bus = z[2*`DP_WIDTH-1:`DP_WIDTH];
        end else if (zLowOut) begin
            bus = z[`DP_WIDTH-1:0];
        end else if (mdrOut) begin
            bus = mdr;
        end else if (inPortOut) begin
            bus = inPort;
        end else if (cSignOut) begin
            bus = cSign;
        end else begin
            bus = '0;                     // idle bus
        end
    end

    // ALU strobes to an operation, first one wins
    always_comb begin
        if (add) begin
            aluOp = datapathPkg::aluAdd;
        end else if (sub) begin
            aluOp = datapathPkg::aluSub;
        end else if (andOp) begin
            aluOp = datapathPkg::aluAnd;
        end else if (orOp) begin
            aluOp = datapathPkg::aluOr;
        end else if (shl) begin
            aluOp = datapathPkg::aluShl;
        end else if (shr) begin
            aluOp = datapathPkg::aluShr;
        end else if (neg) begin
            aluOp = datapathPkg::aluNeg;
        end else if (notOp) begin
            aluOp = datapathPkg::aluNot;
        end else if (mul) begin
            aluOp = datapathPkg::aluMul;
        end else if (incPc) begin
            aluOp = datapathPkg::aluInc;
        end else begin
            aluOp = datapathPkg::aluPass;
        end
    end

    assign mdrNext = mdRead ? memData : bus;   // memory data or bus into MDR

    // special registers, each loads from the bus on its strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            pc      <= '0;
            ir      <= '0;
            y       <= '0;
            z       <= '0;
            mar     <= '0;
            mdr     <= '0;
            outPort <= '0;
        end else begin
            if (pcIn) begin
                pc <= bus;
            end
            if (irIn) begin
                ir <= bus;
            end
            if (yIn) begin
                y <= bus;
            end
            if (zHighIn) begin
                z[2*`DP_WIDTH-1:`DP_WIDTH] <= aluResult[2*`DP_WIDTH-1:`DP_WIDTH];
            end
            if (zLowIn) begin
                z[`DP_WIDTH-1:0] <= aluResult[`DP_WIDTH-1:0];
            end
            if (marIn) begin
                mar <= bus;
            end
            if (mdrIn) begin
                mdr <= mdrNext;
            end
            if (outPortIn) begin
                outPort <= bus;
            end
        end
    end

    selectEncode uSelectEncode (
        .ir          (ir),
        .gra         (gra),
        .grb         (grb),
        .grc         (grc),
        .rIn         (rIn),
        .rOut        (rOut),
        .baOut       (baOut),
        .index       (regIndex),
        .writeEnable (regWrite),
        .readEnable  (regRead),
        .cSign       (cSign)
    );

    registerFile uRegisterFile (
        .clock       (clock),
        .reset       (reset),
        .writeEnable (regWrite),
        .readEnable  (regRead),
        .baOut       (baOut),
        .index       (regIndex),
        .busIn       (bus),
        .readData    (regData)
    );

    alu uAlu (
        .op     (aluOp),
        .a      (y),
        .b      (bus),
        .result (aluResult)
    );

    memory uMemory (
        .clock     (clock),
        .reset     (reset),
        .read      (read),
        .write     (write),
        .address   (mar[AddrBits-1:0]),   // word address, upper MAR bits unused
        .writeData (mdr),
        .readData  (memData)
    );

endmodule

// ==== rtl/datapathPkg.sv ====
`include "datapath_config.svh"

package datapathPkg;

    // one word on the shared bus
    typedef logic [`DP_WIDTH-1:0] wordT;

    // index into the general register file
    typedef logic [$clog2(`DP_REGS)-1:0] regIndexT;

    // ALU operation picked from the ALU strobes
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,     // a + b
        aluSub  = 4'd1,     // a - b
        aluAnd  = 4'd2,     // a & b
        aluOr   = 4'd3,     // a | b
        aluShl  = 4'd4,     // a << b[4:0]
        aluShr  = 4'd5,     // a >> b[4:0], logical
        aluNeg  = 4'd6,     // two's complement of b
        aluNot  = 4'd7,     // ones' complement of b
        aluMul  = 4'd8,     // signed a * b, full 64 bits
        aluInc  = 4'd9,     // b + 1, used for the PC
        aluPass = 4'd10     // b passes through
    } aluOpT;

endpackage

// ==== rtl/memory.sv ====
`include "datapath_config.svh"

module memory (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              read,
    input  logic                              write,
    input  logic [$clog2(`DP_MEM_DEPTH)-1:0]  address,
    input  datapathPkg::wordT                 writeData,
    output datapathPkg::wordT                 readData
);

    datapathPkg::wordT ram [`DP_MEM_DEPTH];

    // write port, MDR into the word at MAR
    always_ff @(posedge clock) begin
        if (write) begin
            ram[address] <= writeData;
        end
    end

    // registered read, holds its value until the next read strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            readData <= '0;
        end else if (read) begin
            readData <= ram[address];
        end
    end

endmodule

// ==== rtl/registerFile.sv ====
`include "datapath_config.svh"

module registerFile (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  writeEnable,
    input  logic                  readEnable,
    input  logic                  baOut,
    input  datapathPkg::regIndexT index,
    input  datapathPkg::wordT     busIn,
    output datapathPkg::wordT     readData
);

    datapathPkg::wordT regs [`DP_REGS];     // R0 .. R15

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DP_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[index] <= busIn;               // write port fed from the bus
        end
    end

    // single read port onto the bus
    always_comb begin
        if (!readEnable) begin
            readData = '0;
        end else if (baOut && (index == '0)) begin
            readData = '0;                      // base-address mode, R0 is zero
        end else begin
            readData = regs[index];
        end
    end

endmodule

// ==== rtl/selectEncode.sv ====
`include "datapath_config.svh"

module selectEncode (
    input  datapathPkg::wordT     ir,
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  rIn,
    input  logic                  rOut,
    input  logic                  baOut,
    output datapathPkg::regIndexT index,
    output logic                  writeEnable,
    output logic                  readEnable,
    output datapathPkg::wordT     cSign
);

    localparam int IndexBits = $bits(datapathPkg::regIndexT);

    datapathPkg::regIndexT raField;
    datapathPkg::regIndexT rbField;
    datapathPkg::regIndexT rcField;
    logic                  anySelect;

    assign raField = ir[`DP_RA_LSB +: IndexBits];
    assign rbField = ir[`DP_RB_LSB +: IndexBits];
    assign rcField = ir[`DP_RC_LSB +: IndexBits];

    // the control step raises one select strobe, fields are OR-ed together
    assign index = ({IndexBits{gra}} & raField)
                 | ({IndexBits{grb}} & rbField)
                 | ({IndexBits{grc}} & rcField);

    assign anySelect = gra | grb | grc;

    // no register takes part unless a field was selected
    assign writeEnable = rIn & anySelect;
    assign readEnable  = (rOut | baOut) & anySelect;

    // C constant, sign bit is ir[18]
    assign cSign = {{(`DP_WIDTH - `DP_C_BITS){ir[`DP_C_BITS-1]}}, ir[`DP_C_BITS-1:0]};

endmodule

// ==== run.sh ====
#!/bin/sh
# build the datapath testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f flist.f --top-module dataPathTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== testbench/dataPathTb.sv ====
`include "datapath_config.svh"

module dataPathTb;

    localparam int CycleLimit = 2000;   // the tests take under two hundred cycles

    logic clock;
    logic reset;
    logic pcIn, irIn, yIn, zHighIn, zLowIn, marIn, mdrIn, outPortIn, rIn;
    logic pcOut, zHighOut, zLowOut, mdrOut, inPortOut, cSignOut, rOut;
    logic gra, grb, grc, baOut;
    logic mdRead, read, write;
    logic add, sub, andOp, orOp, shl, shr, neg, notOp, mul, incPc;
    datapathPkg::wordT inPort;
    datapathPkg::wordT outPort;

    integer seed;
    int     errors;
    int     checks;
    int     cycleCount = 0;

    dataPath u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic clearStrobes();
        {pcIn, irIn, yIn, zHighIn, zLowIn, marIn, mdrIn, outPortIn, rIn,
         pcOut, zHighOut, zLowOut, mdrOut, inPortOut, cSignOut, rOut,
         gra, grb, grc, baOut, mdRead, read, write,
         add, sub, andOp, orOp, shl, shr, neg, notOp, mul, incPc} <= '0;
    endtask

    // one control step whose strobes hold until the next edge
    task automatic nextPhase();
        @(posedge clock);
        clearStrobes();
    endtask

    task automatic checkWord(input string name, input datapathPkg::wordT actual,
                             input datapathPkg::wordT expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // outPortIn is raised in the current phase and the port is read after it settles
    task automatic captureOut(input string name, input datapathPkg::wordT expected);
        nextPhase();
        @(negedge clock);
        checkWord(name, outPort, expected);
    endtask

    task automatic busFromInPort(input datapathPkg::wordT value);
        inPort <= value;
        inPortOut <= 1'b1;
    endtask

    task automatic loadIrRa(input datapathPkg::regIndexT idx);
        nextPhase();
        busFromInPort({5'b0, idx, 23'b0});     // only the ra field is set
        irIn <= 1'b1;
    endtask

    task automatic writeReg(input datapathPkg::regIndexT idx, input datapathPkg::wordT value);
        loadIrRa(idx);
        nextPhase();
        busFromInPort(value);
        gra <= 1'b1;
        rIn <= 1'b1;
    endtask

    task automatic checkReg(input datapathPkg::regIndexT idx, input logic useBa,
                            input datapathPkg::wordT expected);
        loadIrRa(idx);
        nextPhase();
        gra <= 1'b1;
        if (useBa) begin
            baOut <= 1'b1;
        end else begin
            rOut <= 1'b1;
        end
        outPortIn <= 1'b1;
        captureOut($sformatf("R%0d %s", idx, useBa ? "baOut" : "rOut"), expected);
    endtask

    task automatic storeWord(input datapathPkg::wordT addr, input datapathPkg::wordT data);
        nextPhase();
        busFromInPort(addr);
        marIn <= 1'b1;
        nextPhase();
        busFromInPort(data);
        mdrIn <= 1'b1;
        nextPhase();
        write <= 1'b1;
    endtask

    task automatic loadY(input datapathPkg::wordT value);
        nextPhase();
        busFromInPort(value);
        yIn <= 1'b1;
    endtask

    task automatic raiseOp(input datapathPkg::aluOpT op);
        case (op)
            datapathPkg::aluAdd: add <= 1'b1;
            datapathPkg::aluSub: sub <= 1'b1;
            datapathPkg::aluAnd: andOp <= 1'b1;
            datapathPkg::aluOr:  orOp <= 1'b1;
            datapathPkg::aluShl: shl <= 1'b1;
            datapathPkg::aluShr: shr <= 1'b1;
            datapathPkg::aluNeg: neg <= 1'b1;
            datapathPkg::aluNot: notOp <= 1'b1;
            datapathPkg::aluMul: mul <= 1'b1;
            default:             incPc <= 1'b1;
        endcase
    endtask

    // Z low expected from Y (a) and the bus (b)
    function automatic datapathPkg::wordT expectedLow(input datapathPkg::aluOpT op,
                                                      input datapathPkg::wordT a,
                                                      input datapathPkg::wordT b);
        case (op)
            datapathPkg::aluAdd: return a + b;
            datapathPkg::aluSub: return a - b;
            datapathPkg::aluAnd: return a & b;
            datapathPkg::aluOr:  return a | b;
            datapathPkg::aluShl: return a << b[4:0];
            datapathPkg::aluShr: return a >> b[4:0];
            datapathPkg::aluNeg: return ~b + 32'd1;
            datapathPkg::aluNot: return ~b;
            default:             return b + 32'd1;
        endcase
    endfunction

    task automatic resetState();
        @(negedge clock);
        checkWord("outPort", outPort, '0);
        checkReg(4'd5, 1'b0, '0);
    endtask

    task automatic memoryRoundTrip();
        datapathPkg::wordT addr;
        datapathPkg::wordT data;
        for (int i = 0; i < 4; i++) begin
            addr = {$random(seed)} % `DP_MEM_DEPTH;
            addr = (addr == '0) ? 32'd1 : addr;  // word 0 holds the instruction later
            data = $random(seed);
            storeWord(addr, data);
            nextPhase();
            busFromInPort('0);
            mdrIn <= 1'b1;
            nextPhase();
            read <= 1'b1;
            nextPhase();
            mdRead <= 1'b1;
            mdrIn <= 1'b1;
            nextPhase();
            mdrOut <= 1'b1;
            outPortIn <= 1'b1;
            captureOut($sformatf("MDR from word %0d", addr), data);
        end
    endtask

    task automatic oriSequence();
        datapathPkg::wordT r4Value;
        datapathPkg::wordT cExt;
        r4Value = $random(seed);
        cExt = {13'h1fff, 19'h41234};          // C sign bit 18 is set
        storeWord('0, {5'b01010, 4'd3, 4'd4, 19'h41234});
        writeReg(4'd4, r4Value);
        nextPhase();
        busFromInPort('0);
        pcIn <= 1'b1;
        nextPhase();                            // T0
        pcOut <= 1'b1;
        marIn <= 1'b1;
        incPc <= 1'b1;
        zLowIn <= 1'b1;
        nextPhase();                            // T1
        zLowOut <= 1'b1;
        pcIn <= 1'b1;
        read <= 1'b1;
        nextPhase();                            // T2
        mdRead <= 1'b1;
        mdrIn <= 1'b1;
        nextPhase();                            // T3
        mdrOut <= 1'b1;
        irIn <= 1'b1;
        nextPhase();                            // T4
        grb <= 1'b1;
        rOut <= 1'b1;
        yIn <= 1'b1;
        nextPhase();                            // T5
        cSignOut <= 1'b1;
        orOp <= 1'b1;
        zLowIn <= 1'b1;
        nextPhase();                            // T6
        zLowOut <= 1'b1;
        gra <= 1'b1;
        rIn <= 1'b1;
        nextPhase();
        pcOut <= 1'b1;
        outPortIn <= 1'b1;
        captureOut("PC", 32'd1);
        checkReg(4'd3, 1'b0, r4Value | cExt);
    endtask

    task automatic aluOperations();
        datapathPkg::aluOpT op;
        datapathPkg::wordT  a;
        datapathPkg::wordT  b;
        for (int k = 0; k < 20; k++) begin
            op = datapathPkg::aluOpT'(k % 10);
            if (op != datapathPkg::aluMul) begin
                a = $random(seed);
                b = $random(seed);
                loadY(a);
                nextPhase();
                busFromInPort(b);
                raiseOp(op);
                zLowIn <= 1'b1;
                nextPhase();
                zLowOut <= 1'b1;
                outPortIn <= 1'b1;
                captureOut($sformatf("zLow %s", op.name()), expectedLow(op, a, b));
            end
        end
    endtask

    task automatic signedMultiply();
        datapathPkg::wordT a;
        datapathPkg::wordT b;
        logic [63:0]       product;
        for (int i = 0; i < 4; i++) begin
            a = $random(seed);
            b = $random(seed);
            product = {{32{a[31]}}, a} * {{32{b[31]}}, b};   // signed product modulo 2**64
            loadY(a);
            nextPhase();
            busFromInPort(b);
            raiseOp(datapathPkg::aluMul);
            zHighIn <= 1'b1;
            zLowIn <= 1'b1;
            nextPhase();
            zHighOut <= 1'b1;
            outPortIn <= 1'b1;
            captureOut("zHigh mul", product[63:32]);
            nextPhase();
            zLowOut <= 1'b1;
            outPortIn <= 1'b1;
            captureOut("zLow mul", product[31:0]);
        end
    endtask

    task automatic baseAddressMode();
        datapathPkg::wordT r0Value;
        datapathPkg::wordT r7Value;
        r0Value = $random(seed) | 32'h1;       // nonzero
        r7Value = $random(seed);
        writeReg(4'd0, r0Value);
        writeReg(4'd7, r7Value);
        checkReg(4'd0, 1'b0, r0Value);
        checkReg(4'd0, 1'b1, '0);
        checkReg(4'd7, 1'b1, r7Value);
    endtask

    initial begin
        seed = 32'hfe7080e5;
        errors = 0;
        checks = 0;
        inPort <= '0;
        reset <= 1'b1;
        clearStrobes();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        resetState();
        memoryRoundTrip();
        oriSequence();
        aluOperations();
        signedMultiply();
        baseAddressMode();
        nextPhase();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
